/* hw/unwrap_pkg.sv */
`default_nettype none

package unwrap_pkg;

	typedef logic [31:0] word_t; // one stream word

	// decoded keyboard event, one per kbd_valid_i strobe
	typedef struct packed {
		logic [7:0] code; // ascii byte
		logic       enter; // end of passphrase
		logic       clear; // start over
	} kbd_evt_t;

	typedef struct packed {
		logic done; // verdict strobe
		logic pass; // digest matched tag
	} chk_res_t;

	localparam word_t DIGEST_SEED = 32'h811c_9dc5; // empty digest
	localparam int    DIGEST_ROT  = 5; // left rotate per byte

	// one byte into the rolling digest: xor low byte, then rotate left
	function automatic word_t digest_step(input word_t d, input logic [7:0] b);
		word_t x;
		x = {d[31:8], d[7:0] ^ b};
		return {x[31-DIGEST_ROT:0], x[31:32-DIGEST_ROT]};
	endfunction

endpackage

`default_nettype wire

/* hw/key_loader.sv */
`default_nettype none

module key_loader #(
	parameter int KEY_W = 64
) (
	input  logic              clk,
	input  logic              rst,
	input  unwrap_pkg::word_t key_data_i,
	input  logic              key_valid_i,
	output logic              key_ready_o,
	output logic [KEY_W-1:0]  exp_o,
	output logic [KEY_W-1:0]  mod_o,
	output unwrap_pkg::word_t tag_o,
	output logic              key_loaded_o
);
	localparam int NW   = KEY_W / 32; // words per field
	localparam int NTOT = 2 * NW + 1; // exp, mod, tag
	localparam int CW   = $clog2(NTOT + 1);

	logic [CW-1:0]     cnt; // words taken so far
	logic              take;
	logic [KEY_W+31:0] exp_sh; // new word on top, low word drops toward bit 0
	logic [KEY_W+31:0] mod_sh;

	assign take         = key_valid_i && key_ready_o;
	assign key_loaded_o = !key_ready_o; // ready never comes back
	assign exp_sh       = {key_data_i, exp_o};
	assign mod_sh       = {key_data_i, mod_o};

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt         <= '0;
			key_ready_o <= 1'b1;
		end else if (take) begin
			cnt <= cnt + 1'b1;
			if (cnt == CW'(NTOT - 1))
				key_ready_o <= 1'b0; // tag word was the last
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			if (cnt < CW'(NW))
				exp_o <= exp_sh[KEY_W+31:32]; // exponent, low word first
			else if (cnt < CW'(2 * NW))
				mod_o <= mod_sh[KEY_W+31:32]; // modulus
			else
				tag_o <= key_data_i; // passphrase tag
		end
	end

endmodule

`default_nettype wire

/* hw/pass_check.sv */
`default_nettype none

module pass_check #(
	parameter int PASS_MAX = 56
) (
	input  logic                 clk,
	input  logic                 rst,
	input  unwrap_pkg::kbd_evt_t kbd_i,
	input  logic                 kbd_valid_i,
	input  logic                 pass_en_i,
	input  logic                 pass_flush_i,
	input  unwrap_pkg::word_t    tag_i,
	output unwrap_pkg::chk_res_t chk_o
);
	import unwrap_pkg::*;

	localparam int BW = $clog2(PASS_MAX + 1);

	word_t         digest; // rolling digest of typed bytes
	logic [BW-1:0] n_bytes; // bytes folded in
	logic          evt;

	assign evt = kbd_valid_i && pass_en_i; // keyboard ignored outside the phase

	always_ff @(posedge clk) begin
		if (rst) begin
			digest  <= DIGEST_SEED;
			n_bytes <= '0;
			chk_o   <= '0;
		end else begin
			chk_o.done <= 1'b0; // strobe
			if (pass_flush_i) begin
				digest  <= DIGEST_SEED; // retry after a wrong passphrase
				n_bytes <= '0;
			end else if (evt) begin
				if (kbd_i.clear) begin
					digest  <= DIGEST_SEED;
					n_bytes <= '0;
				end else if (kbd_i.enter) begin
					chk_o.done <= 1'b1;
					chk_o.pass <= (digest == tag_i);
				end else if (n_bytes < BW'(PASS_MAX)) begin
					digest  <= digest_step(digest, kbd_i.code);
					n_bytes <= n_bytes + 1'b1;
				end // past the limit, bytes are dropped
			end
		end
	end

endmodule

`default_nettype wire

/* hw/modexp_unit.sv */
`default_nettype none

module modexp_unit #(
	parameter int KEY_W = 64
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall_i,
	input  logic             start_i,
	input  logic [KEY_W-1:0] base_i,
	input  logic [KEY_W-1:0] exp_i,
	input  logic [KEY_W-1:0] mod_i,
	output logic             done_o,
	output logic [KEY_W-1:0] result_o,
	input  logic             take_i
);
	localparam int IW = $clog2(KEY_W);

	typedef enum logic [1:0] {
		M_IDLE,
		M_SQR, // acc = acc * acc
		M_MUL, // acc = acc * base
		M_DONE
	} mstate_t;

	mstate_t          state;
	logic [KEY_W-1:0] acc; // running power, also the multiplier
	logic [KEY_W-1:0] base_q;
	logic [KEY_W-1:0] exp_q; // msb is the bit being worked on
	logic [KEY_W-1:0] prod; // partial product of the current multiply
	logic [KEY_W-1:0] mcand;
	logic [IW-1:0]    bit_idx; // exponent bits left
	logic [IW-1:0]    mul_idx; // multiplier bit, top down
	logic [KEY_W:0]   mod_x;
	logic [KEY_W:0]   dbl;
	logic [KEY_W:0]   dbl_r;
	logic [KEY_W:0]   sum;
	logic [KEY_W:0]   nxt;
	logic             mul_last;
	logic             launch;
	logic             need_mul;

	assign mcand    = (state == M_MUL) ? base_q : acc;
	assign mod_x    = {1'b0, mod_i};
	assign dbl      = {prod, 1'b0}; // 2p < 2m
	assign dbl_r    = (dbl >= mod_x) ? dbl - mod_x : dbl;
	assign sum      = dbl_r + (acc[mul_idx] ? {1'b0, mcand} : '0);
	assign nxt      = (sum >= mod_x) ? sum - mod_x : sum; // back below m
	assign mul_last = (mul_idx == '0);
	assign launch   = start_i && ((state == M_IDLE) || (state == M_DONE));
	assign need_mul = (state == M_SQR) && exp_q[KEY_W-1];
	assign done_o   = (state == M_DONE);
	assign result_o = acc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= M_IDLE;
		end else if (!stall_i) begin
			case (state)
				M_IDLE: if (launch) state <= M_SQR;
				M_SQR, M_MUL: begin
					if (mul_last) begin
						if (need_mul)
							state <= M_MUL;
						else if (bit_idx == '0)
							state <= M_DONE; // last exponent bit finished
						else
							state <= M_SQR;
					end
				end
				M_DONE: begin
					if (launch)
						state <= M_SQR; // back to back with the hand-off
					else if (take_i)
						state <= M_IDLE;
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			if (launch) begin
				acc     <= KEY_W'(1);
				base_q  <= base_i;
				exp_q   <= exp_i;
				prod    <= '0;
				bit_idx <= IW'(KEY_W - 1);
				mul_idx <= IW'(KEY_W - 1);
			end else if ((state == M_SQR) || (state == M_MUL)) begin
				if (mul_last) begin
					acc     <= nxt[KEY_W-1:0]; // product complete
					prod    <= '0;
					mul_idx <= IW'(KEY_W - 1);
					if (!need_mul) begin
						exp_q   <= exp_q << 1; // next exponent bit
						bit_idx <= bit_idx - 1'b1;
					end
				end else begin
					prod    <= nxt[KEY_W-1:0];
					mul_idx <= mul_idx - 1'b1;
				end
			end
		end
	end

	// base from the key stream must already be reduced by the loaded modulus
	assert property (@(posedge clk) disable iff (rst)
		start_i && !stall_i |-> base_i < mod_i);

	// a new job only on an idle unit or while the old result is taken
	assert property (@(posedge clk) disable iff (rst)
		start_i && !stall_i |-> (state == M_IDLE) || ((state == M_DONE) && take_i));

endmodule

`default_nettype wire

/* hw/key_emit.sv */
`default_nettype none

module key_emit #(
	parameter int KEY_W = 64
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              load_i,
	input  logic [KEY_W-1:0]  data_i,
	output logic              busy_o,
	output unwrap_pkg::word_t out_data_o,
	output logic              out_valid_o,
	input  logic              out_ready_i
);
	localparam int NW = KEY_W / 32;
	localparam int LW = $clog2(NW + 1);

	logic [KEY_W-1:0] buf_q; // remaining words, next one at the bottom
	logic [LW-1:0]    left; // words still to send
	logic             xfer;

	assign busy_o      = (left != '0);
	assign out_valid_o = busy_o;
	assign out_data_o  = buf_q[31:0];
	assign xfer        = out_valid_o && out_ready_i;

	always_ff @(posedge clk) begin
		if (rst)
			left <= '0;
		else if (load_i)
			left <= LW'(NW);
		else if (xfer)
			left <= left - 1'b1; // advance only on a transfer
	end

	always_ff @(posedge clk) begin
		if (load_i)
			buf_q <= data_i;
		else if (xfer)
			buf_q <= buf_q >> 32; // low word first
	end

	// held word must not move under back-pressure
	assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

	// the sequencer waits for the previous result to drain
	assert property (@(posedge clk) disable iff (rst) load_i |-> !busy_o);

endmodule

`default_nettype wire

/* hw/unwrap_ctrl.sv */
`default_nettype none

module unwrap_ctrl #(
	parameter int KEY_W = 64
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall_i,
	input  logic                 key_loaded_i,
	output logic                 pass_en_o,
	output logic                 pass_flush_o,
	input  unwrap_pkg::chk_res_t chk_i,
	input  unwrap_pkg::word_t    wrap_data_i,
	input  logic                 wrap_valid_i,
	output logic                 wrap_ready_o,
	output logic [KEY_W-1:0]     base_o,
	output logic                 mx_start_o,
	input  logic                 mx_done_i,
	output logic                 mx_take_o,
	output logic                 em_load_o,
	input  logic                 em_busy_i,
	output logic                 led_pass_o,
	output logic                 led_fail_o
);
	import unwrap_pkg::*;

	localparam int NW  = KEY_W / 32;
	localparam int WCW = $clog2(NW + 1);

	typedef enum logic [2:0] {
		S_LOAD, // key material streaming in
		S_PASS, // typing
		S_CHECK, // wrong passphrase, digest restarts
		S_COLLECT, // wrapped key words
		S_COMPUTE, // issue to modexp
		S_HANDOFF // modexp still holds the previous result
	} state_t;

	state_t            state;
	logic [WCW-1:0]    wcnt; // words of the current key
	logic              mx_busy; // modexp owns a job
	chk_res_t          chk_hold; // verdict that came in during a stall
	chk_res_t          verdict;
	logic              wrap_take;
	logic              mx_free;
	logic [KEY_W+31:0] base_sh;

	assign verdict      = chk_i.done ? chk_i : chk_hold;
	assign pass_en_o    = (state == S_PASS);
	assign pass_flush_o = (state == S_CHECK);
	assign wrap_ready_o = (state == S_COLLECT) && !stall_i;
	assign wrap_take    = wrap_ready_o && wrap_valid_i;
	assign em_load_o    = mx_done_i && !em_busy_i && !stall_i; // result moves to emitter
	assign mx_take_o    = em_load_o;
	assign mx_free      = !mx_busy || mx_take_o;
	assign mx_start_o   = ((state == S_COMPUTE) || (state == S_HANDOFF)) && mx_free && !stall_i;
	assign base_sh      = {wrap_data_i, base_o};

	always_ff @(posedge clk) begin
		if (rst)
			chk_hold <= '0;
		else if (stall_i && chk_i.done)
			chk_hold <= chk_i; // keyboard side runs on during stall
		else if (!stall_i)
			chk_hold <= '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= S_LOAD;
			wcnt       <= '0;
			mx_busy    <= 1'b0;
			led_pass_o <= 1'b0;
			led_fail_o <= 1'b0;
		end else if (!stall_i) begin
			if (mx_start_o)
				mx_busy <= 1'b1;
			else if (mx_take_o)
				mx_busy <= 1'b0;
			case (state)
				S_LOAD: if (key_loaded_i) state <= S_PASS;
				S_PASS: begin
					if (verdict.done && verdict.pass) begin
						led_pass_o <= 1'b1; // sticky from here on
						led_fail_o <= 1'b0;
						state      <= S_COLLECT;
					end else if (verdict.done) begin
						led_fail_o <= 1'b1;
						state      <= S_CHECK;
					end
				end
				S_CHECK: state <= S_PASS;
				S_COLLECT: begin
					if (wrap_take && (wcnt == WCW'(NW - 1))) begin
						wcnt  <= '0;
						state <= S_COMPUTE; // ready drops next cycle
					end else if (wrap_take) begin
						wcnt <= wcnt + 1'b1;
					end
				end
				S_COMPUTE: state <= mx_start_o ? S_COLLECT : S_HANDOFF;
				S_HANDOFF: if (mx_start_o) state <= S_COLLECT;
				default: state <= S_LOAD;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wrap_take)
			base_o <= base_sh[KEY_W+31:32]; // low word first
	end

	assert property (@(posedge clk) disable iff (rst)
		state inside {S_LOAD, S_PASS, S_CHECK, S_COLLECT, S_COMPUTE, S_HANDOFF});

	// modexp only reports done for a job that was issued here
	assert property (@(posedge clk) disable iff (rst) mx_done_i |-> mx_busy);

endmodule

`default_nettype wire

/* hw/key_unwrap_top.sv */
`default_nettype none

module key_unwrap_top #(
	parameter int KEY_W    = 64,
	parameter int PASS_MAX = 56
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall_i,
	input  unwrap_pkg::word_t    key_data_i,
	input  logic                 key_valid_i,
	output logic                 key_ready_o,
	input  unwrap_pkg::word_t    wrap_data_i,
	input  logic                 wrap_valid_i,
	output logic                 wrap_ready_o,
	output unwrap_pkg::word_t    out_data_o,
	output logic                 out_valid_o,
	input  logic                 out_ready_i,
	input  unwrap_pkg::kbd_evt_t kbd_i,
	input  logic                 kbd_valid_i,
	output logic                 led_pass_o,
	output logic                 led_fail_o
);
	import unwrap_pkg::*;

	logic [KEY_W-1:0] exp_w; // private exponent
	logic [KEY_W-1:0] mod_w;
	word_t            tag_w; // passphrase digest to match
	logic             key_loaded;
	logic             pass_en;
	logic             pass_flush;
	chk_res_t         chk;
	logic [KEY_W-1:0] base_w; // collected wrapped key
	logic             mx_start;
	logic             mx_done;
	logic             mx_take;
	logic [KEY_W-1:0] mx_result;
	logic             em_load;
	logic             em_busy;

	key_loader #(.KEY_W(KEY_W)) i_key_loader (
		.clk, .rst, .key_data_i, .key_valid_i, .key_ready_o,
		.exp_o(exp_w), .mod_o(mod_w), .tag_o(tag_w), .key_loaded_o(key_loaded)
	);

	pass_check #(.PASS_MAX(PASS_MAX)) i_pass_check (
		.clk, .rst, .kbd_i, .kbd_valid_i, .pass_en_i(pass_en),
		.pass_flush_i(pass_flush), .tag_i(tag_w), .chk_o(chk)
	);

	modexp_unit #(.KEY_W(KEY_W)) i_modexp_unit (
		.clk, .rst, .stall_i, .start_i(mx_start), .base_i(base_w), .exp_i(exp_w),
		.mod_i(mod_w), .done_o(mx_done), .result_o(mx_result), .take_i(mx_take)
	);

	key_emit #(.KEY_W(KEY_W)) i_key_emit (
		.clk, .rst, .load_i(em_load), .data_i(mx_result), .busy_o(em_busy),
		.out_data_o, .out_valid_o, .out_ready_i
	);

	unwrap_ctrl #(.KEY_W(KEY_W)) i_unwrap_ctrl (
		.clk, .rst, .stall_i, .key_loaded_i(key_loaded), .pass_en_o(pass_en),
		.pass_flush_o(pass_flush), .chk_i(chk), .wrap_data_i, .wrap_valid_i,
		.wrap_ready_o, .base_o(base_w), .mx_start_o(mx_start), .mx_done_i(mx_done),
		.mx_take_o(mx_take), .em_load_o(em_load), .em_busy_i(em_busy),
		.led_pass_o, .led_fail_o
	);

endmodule

`default_nettype wire

/* sim/tb_key_unwrap.sv */
`default_nettype none

module tb_key_unwrap;
	timeunit 1ns;
	timeprecision 100ps;

	import unwrap_pkg::*;

	localparam int KEY_W    = 64;
	localparam int PASS_MAX = 56;
	localparam int NW       = KEY_W / 32;
	localparam int NKEYS    = 8;
	localparam int TOTAL    = NKEYS * NW; // result words expected
	localparam int CYC_LIMIT = NKEYS * 2 * KEY_W * (KEY_W + 2) + 2000;
	localparam logic [KEY_W-1:0] EXPONENT = 64'h5b1e_03c7_a9f2_6d85;
	localparam logic [KEY_W-1:0] MODULUS  = 64'hd3a7_1b5c_9e2f_4c61; // odd, top bit set
	localparam string PASS_OK = "open sesame";

	logic clk = 1'b0; // low from the start, no edge at time zero
	logic rst, stall_i;
	word_t key_data_i, wrap_data_i, out_data_o;
	logic key_valid_i, key_ready_o, wrap_valid_i, wrap_ready_o;
	logic out_valid_o, out_ready_i, kbd_valid_i, led_pass_o, led_fail_o;
	kbd_evt_t kbd_i;

	logic [31:0]      lfsr_q = 32'h6e8d_7448;
	logic [KEY_W-1:0] keys [NKEYS];
	word_t            exp_q [$]; // reference words, oldest first
	word_t            exp_head; // word the next transfer must carry
	word_t            prev_data;
	word_t            tb_digest; // model of the DUT digest
	int               n_typed;
	int               n_out = 0;
	int               val_errs = 0;
	int               other_errs = 0;
	int               cyc;
	logic             pass_exp = 1'b0; // verdict the next enter should give
	logic             keys_sent = 1'b0;
	logic             stall_on = 1'b0;

	key_unwrap_top #(.KEY_W(KEY_W), .PASS_MAX(PASS_MAX)) i_key_unwrap_top (.*);

	initial begin
		forever #2 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [KEY_W-1:0] take_bits(input int n);
		logic [KEY_W-1:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			r      = {r[KEY_W-2:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic word_t fold_byte(input word_t d, input logic [7:0] b);
		word_t x;
		x = d ^ {24'h0, b};
		return (x << DIGEST_ROT) | (x >> (32 - DIGEST_ROT));
	endfunction

	function automatic word_t digest_of(input string s);
		word_t d;
		d = DIGEST_SEED;
		for (int i = 0; i < s.len() && i < PASS_MAX; i++)
			d = fold_byte(d, s[i]);
		return d;
	endfunction

	// right to left binary powering, independent of the DUT scan order
	function automatic logic [KEY_W-1:0] mod_pow(input logic [KEY_W-1:0] b, e, m);
		logic [2*KEY_W-1:0] r;
		logic [2*KEY_W-1:0] x;
		r = 1;
		x = b;
		for (int i = 0; i < KEY_W; i++) begin
			if (e[i])
				r = (r * x) % m;
			x = (x * x) % m;
		end
		return r[KEY_W-1:0];
	endfunction

	task automatic report_mismatch(input string sig, input logic [63:0] want, got);
		val_errs++;
		$display("ERROR t=%0t %s expected %h got %h", $time, sig, want, got);
	endtask

	task automatic report_failure(input string what);
		other_errs++;
		$display("ERROR t=%0t %s", $time, what);
	endtask

	task automatic print_counts();
		$display("value errors %0d, other errors %0d, words out %0d of %0d",
			val_errs, other_errs, n_out, TOTAL);
	endtask

	task automatic send_key_word(input word_t w);
		key_data_i  = w;
		key_valid_i = 1'b1;
		do @(posedge clk); while (!key_ready_o); // ready seen before the edge
		@(negedge clk);
		key_valid_i = 1'b0;
	endtask

	task automatic send_wrap_word(input word_t w);
		wrap_data_i  = w;
		wrap_valid_i = 1'b1;
		do @(posedge clk); while (!wrap_ready_o);
		@(negedge clk);
		wrap_valid_i = 1'b0;
	endtask

	task automatic type_text(input string s);
		for (int i = 0; i < s.len(); i++) begin
			kbd_i       = '{code: s[i], enter: 1'b0, clear: 1'b0};
			kbd_valid_i = 1'b1;
			if (n_typed < PASS_MAX) begin
				tb_digest = fold_byte(tb_digest, s[i]);
				n_typed++;
			end
			@(negedge clk);
		end
		kbd_valid_i = 1'b0;
	endtask

	task automatic press_clear();
		kbd_i       = '{code: 8'h00, enter: 1'b0, clear: 1'b1};
		kbd_valid_i = 1'b1;
		tb_digest   = DIGEST_SEED;
		n_typed     = 0;
		@(negedge clk);
		kbd_valid_i = 1'b0;
	endtask

	task automatic press_enter(input word_t tag);
		pass_exp    = (tb_digest == tag);
		kbd_i       = '{code: 8'h00, enter: 1'b1, clear: 1'b0};
		kbd_valid_i = 1'b1;
		@(negedge clk);
		kbd_valid_i = 1'b0;
		repeat (4) @(negedge clk); // verdict, led, then flush back to typing
		if (!pass_exp) begin
			tb_digest = DIGEST_SEED; // DUT restarts after a wrong try
			n_typed   = 0;
		end
	endtask

	// random back-pressure always, stall only once keys flow
	always @(negedge clk) begin
		out_ready_i = (take_bits(2) != '0);
		stall_i     = stall_on && (take_bits(3) == 3'b111);
	end

	always @(posedge clk) begin
		prev_data <= out_data_o;
		if (!rst && out_valid_o && out_ready_i) begin
			n_out++;
			if (exp_q.size() != 0)
				void'(exp_q.pop_front());
			exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
		end
	end

	assert property (@(posedge clk) $fell(rst) |->
		{key_ready_o, wrap_ready_o, out_valid_o, led_pass_o, led_fail_o} == 5'b10000)
		else report_mismatch("key_ready_o,wrap_ready_o,out_valid_o,led_pass_o,led_fail_o",
			5'b10000, $sampled({key_ready_o, wrap_ready_o, out_valid_o, led_pass_o, led_fail_o}));
	assert property (@(posedge clk) disable iff (rst) keys_sent |-> !key_ready_o)
		else report_mismatch("key_ready_o", 0, $sampled(key_ready_o));
	assert property (@(posedge clk) disable iff (rst)
		kbd_valid_i && kbd_i.enter |-> ##2 led_pass_o == pass_exp)
		else report_mismatch("led_pass_o", $sampled(pass_exp), $sampled(led_pass_o));
	assert property (@(posedge clk) disable iff (rst)
		kbd_valid_i && kbd_i.enter |-> ##2 led_fail_o == !pass_exp)
		else report_mismatch("led_fail_o", $sampled(!pass_exp), $sampled(led_fail_o));
	assert property (@(posedge clk) disable iff (rst) led_fail_o |-> !wrap_ready_o)
		else report_mismatch("wrap_ready_o", 0, $sampled(wrap_ready_o));
	assert property (@(posedge clk) disable iff (rst)
		out_valid_o && out_ready_i |-> out_data_o == exp_head)
		else report_mismatch("out_data_o", $sampled(exp_head), $sampled(out_data_o));
	assert property (@(posedge clk) disable iff (rst) out_valid_o && !out_ready_i |=> out_valid_o)
		else report_failure("out_valid_o dropped before the word was taken");
	assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !out_ready_i |=> out_data_o == prev_data)
		else report_mismatch("out_data_o", $sampled(prev_data), $sampled(out_data_o));
	assert property (@(posedge clk) disable iff (rst) out_valid_o && out_ready_i |-> n_out < TOTAL)
		else report_failure("more result words than keys sent");

	initial begin
		cyc = 0;
		while (cyc < CYC_LIMIT) begin
			@(posedge clk);
			cyc++;
		end
		report_failure($sformatf("timeout after %0d cycles", cyc));
		print_counts();
		$display("sim failed");
		$finish;
	end

	initial begin
		word_t            tag;
		logic [KEY_W-1:0] res;
		rst          = 1'b1;
		stall_i      = 1'b0;
		key_data_i   = '0;
		key_valid_i  = 1'b0;
		wrap_data_i  = '0;
		wrap_valid_i = 1'b0;
		out_ready_i  = 1'b1;
		kbd_i        = '0;
		kbd_valid_i  = 1'b0;
		tb_digest    = DIGEST_SEED;
		n_typed      = 0;
		tag          = digest_of(PASS_OK);
		for (int k = 0; k < NKEYS; k++) begin
			keys[k] = take_bits(KEY_W) % MODULUS; // base below modulus
			res     = mod_pow(keys[k], EXPONENT, MODULUS);
			for (int w = 0; w < NW; w++)
				exp_q.push_back(res[32*w +: 32]);
		end
		exp_head = exp_q[0];
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		for (int w = 0; w < NW; w++)
			send_key_word(EXPONENT[32*w +: 32]);
		for (int w = 0; w < NW; w++)
			send_key_word(MODULUS[32*w +: 32]);
		send_key_word(tag);
		keys_sent = 1'b1;
		repeat (3) @(negedge clk);
		type_text("open sesamf"); // one byte off
		press_enter(tag);
		type_text("xq#");
		press_clear();
		type_text(PASS_OK);
		press_enter(tag);
		stall_on = 1'b1;
		for (int k = 0; k < NKEYS; k++)
			for (int w = 0; w < NW; w++)
				send_wrap_word(keys[k][32*w +: 32]);
		wait (n_out == TOTAL);
		repeat (8) @(negedge clk); // room for a stray extra word
		assert (n_out == TOTAL && !out_valid_o)
			else report_failure("output still valid or extra words after the last result");
		print_counts();
		if (val_errs + other_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hw/unwrap_pkg.sv
hw/key_loader.sv
hw/pass_check.sv
hw/modexp_unit.sv
hw/key_emit.sv
hw/unwrap_ctrl.sv
hw/key_unwrap_top.sv
sim/tb_key_unwrap.sv
